//--- sim.f
mips_pkg.sv
mips_fetch.sv
mips_control.sv
mips_regfile.sv
mips_alu.sv
mips_data_mem.sv
mips_core.sv
mips_core_asserts.sv
tb_mips_core.sv

//--- Makefile
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of tee
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_mips_core.sv
// Plays instruction memory for mips_core (64 words) and checks every executed instruction
`timescale 1ns/1ns

module tb_mips_core
    import mips_pkg::*;
();

    localparam int DMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 8;
    // Five tests plus the restart after the mid-program reset
    localparam int TOTAL_INSTRS = 8 + 10 + 7 + 12 + 10;
    localparam int RESET_COUNT  = 6;
    localparam int CYCLE_LIMIT  = (TOTAL_INSTRS * 3) / 2 + RESET_COUNT * RESET_CYCLES;

    logic  clk;
    logic  reset;
    word_t instr;
    word_t pc;
    word_t alu_result;
    logic  mem_read;
    logic  mem_write;
    logic  mem_to_reg;

    word_t  prog [64];
    // Reference model state
    word_t  m_regs [32];
    word_t  m_mem [DMEM_WORDS];
    word_t  m_pc;
    logic   prev_reset = 1'b0;
    integer seed;
    int     err_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;

    mips_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .alu_result (alu_result),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg)
    );

    // Instruction memory read
    assign instr = prog[pc[7:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, funct_t fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rand_imm();
        integer r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            err_count++;
        end
    endtask

    // Executes the instruction at the model pc and compares the DUT outputs
    task automatic step_model();
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     next_pc;
        logic      exp_rd;
        logic      exp_wr;
        logic      exp_m2r;
        logic      wr_en;
        reg_addr_t dest;
        ins     = prog[m_pc[7:2]];
        imm     = {{16{ins[15]}}, ins[15:0]};
        a       = m_regs[ins[25:21]];
        b       = m_regs[ins[20:16]];
        res     = 32'd0;
        next_pc = m_pc + 32'd4;
        exp_rd  = 1'b0;
        exp_wr  = 1'b0;
        exp_m2r = 1'b0;
        wr_en   = 1'b0;
        dest    = ins[20:16];
        case (ins[31:26])
            OP_RTYPE: begin
                dest  = ins[15:11];
                wr_en = 1'b1;
                case (ins[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDI: begin
                res   = a + imm;
                wr_en = 1'b1;
            end
            OP_LW: begin
                res     = a + imm;
                exp_rd  = 1'b1;
                exp_m2r = 1'b1;
            end
            OP_SW: begin
                res    = a + imm;
                exp_wr = 1'b1;
            end
            OP_BEQ: begin
                res = a - b;
                // Word offset from the next sequential address
                if (a == b) begin
                    next_pc = m_pc + 32'd4 + (imm << 2);
                end
            end
            default: ;
        endcase
        check_value("pc", pc, m_pc);
        check_value("alu_result", alu_result, res);
        check_value("mem_read", {31'd0, mem_read}, {31'd0, exp_rd});
        check_value("mem_write", {31'd0, mem_write}, {31'd0, exp_wr});
        check_value("mem_to_reg", {31'd0, mem_to_reg}, {31'd0, exp_m2r});
        // Memory word index is address bits 9:2 for 256 words
        if (exp_wr) begin
            m_mem[res[9:2]] = b;
        end
        if (wr_en && dest != 5'd0) begin
            m_regs[dest] = res;
        end
        if (exp_rd && dest != 5'd0) begin
            m_regs[dest] = m_mem[res[9:2]];
        end
        m_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (prev_reset) begin
                check_value("pc in reset", pc, 32'd0);
            end
            m_pc = 32'd0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = 32'd0;
            end
        end else begin
            step_model();
        end
        prev_reset = reset;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic begin_reset();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
    endtask

    task automatic end_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Unused words decode as an unknown funct and write nothing
    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            prog[i] = 32'd0;
        end
    endtask

    task automatic run_instrs(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s done: %0d errors", name, err_count - errs_before);
    endtask

    task automatic addi_sequence_test();
        int errs;
        errs = err_count;
        begin_reset();
        clear_program();
        prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, rand_imm());
        for (int i = 1; i < 8; i++) begin
            prog[i] = enc_i(OP_ADDI, reg_addr_t'(i), reg_addr_t'(i + 1), rand_imm());
        end
        end_reset();
        run_instrs(8);
        report_test("addi sequence", errs);
    endtask

    task automatic rtype_ops_test();
        int errs;
        errs = err_count;
        begin_reset();
        clear_program();
        // Opposite signs make slt differ from an unsigned compare
        prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, rand_imm() & 16'h7fff);
        prog[1] = enc_i(OP_ADDI, 5'd0, 5'd2, rand_imm() | 16'h8000);
        prog[2] = enc_r(5'd1, 5'd2, 5'd3, FN_ADD);
        prog[3] = enc_r(5'd1, 5'd2, 5'd4, FN_SUB);
        prog[4] = enc_r(5'd1, 5'd2, 5'd5, FN_AND);
        prog[5] = enc_r(5'd1, 5'd2, 5'd6, FN_OR);
        prog[6] = enc_r(5'd1, 5'd2, 5'd7, FN_SLT);
        prog[7] = enc_r(5'd2, 5'd1, 5'd8, FN_SLT);
        // Write to r0 is dropped, so the next add sees zero
        prog[8] = enc_r(5'd1, 5'd2, 5'd0, FN_ADD);
        prog[9] = enc_r(5'd0, 5'd1, 5'd9, FN_ADD);
        end_reset();
        run_instrs(10);
        report_test("r-type ops", errs);
    endtask

    task automatic load_store_test();
        int          errs;
        logic [15:0] off;
        errs = err_count;
        off  = rand_imm();
        begin_reset();
        clear_program();
        prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, rand_imm());
        prog[1] = enc_i(OP_ADDI, 5'd0, 5'd2, rand_imm());
        prog[2] = enc_i(OP_SW, 5'd1, 5'd2, off);
        prog[3] = enc_i(OP_ADDI, 5'd0, 5'd3, 16'd7);
        prog[4] = enc_i(OP_LW, 5'd1, 5'd4, off);
        prog[5] = enc_r(5'd4, 5'd0, 5'd5, FN_ADD);
        prog[6] = enc_r(5'd4, 5'd3, 5'd6, FN_ADD);
        end_reset();
        run_instrs(7);
        report_test("load and store", errs);
    endtask

    task automatic branch_test();
        int errs;
        errs = err_count;
        begin_reset();
        clear_program();
        prog[0]  = enc_i(OP_ADDI, 5'd0, 5'd1, 16'd5);
        prog[1]  = enc_i(OP_ADDI, 5'd0, 5'd2, 16'd5);
        prog[2]  = enc_i(OP_ADDI, 5'd0, 5'd3, 16'd7);
        // Taken branch skips words 4 and 5
        prog[3]  = enc_i(OP_BEQ, 5'd1, 5'd2, 16'd2);
        prog[4]  = enc_i(OP_ADDI, 5'd0, 5'd4, 16'd4);
        prog[5]  = enc_i(OP_ADDI, 5'd0, 5'd4, 16'd5);
        prog[6]  = enc_i(OP_BEQ, 5'd1, 5'd3, 16'd5);
        prog[7]  = enc_i(OP_BEQ, 5'd1, 5'd2, 16'd3);
        prog[9]  = enc_i(OP_ADDI, 5'd6, 5'd6, 16'd1);
        prog[10] = enc_i(OP_ADDI, 5'd0, 5'd7, 16'd10);
        // Backward loop to word 9
        prog[11] = enc_i(OP_BEQ, 5'd1, 5'd2, 16'hfffd);
        end_reset();
        run_instrs(12);
        report_test("branch", errs);
    endtask

    task automatic illegal_and_reset_test();
        int errs;
        errs = err_count;
        begin_reset();
        clear_program();
        // Reads r1 and r4, which any reset clears
        prog[0] = enc_r(5'd1, 5'd4, 5'd7, FN_ADD);
        prog[1] = enc_i(OP_ADDI, 5'd0, 5'd1, rand_imm());
        prog[2] = enc_i(OP_ADDI, 5'd0, 5'd2, rand_imm());
        prog[3] = enc_i(OP_SW, 5'd2, 5'd1, 16'd0);
        // sb is outside the subset and must not overwrite the stored word
        prog[4] = enc_i(6'b101000, 5'd2, 5'd3, 16'd0);
        prog[5] = enc_r(5'd1, 5'd1, 5'd1, 6'b111111);
        prog[6] = enc_i(OP_LW, 5'd2, 5'd4, 16'd0);
        prog[7] = enc_r(5'd1, 5'd4, 5'd5, FN_ADD);
        end_reset();
        run_instrs(8);
        begin_reset();
        end_reset();
        run_instrs(2);
        report_test("illegal and reset", errs);
    endtask

    initial begin
        reset = 1'b1;
        seed  = 32'h5bf4;
        clear_program();
        addi_sequence_test();
        rtype_ops_test();
        load_store_test();
        branch_test();
        illegal_and_reset_test();
        $display("Tests: 5, checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- mips_core_asserts.sv
// Bound to every mips_core instance; checks are off while reset is high except the restart check
`timescale 1ns/1ns

module mips_core_asserts
    import mips_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input word_t pc,
    input logic  mem_read,
    input logic  mem_write
);

    // Fetch only steps by whole words
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc 0x%h is not word aligned", pc);

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    // First cycle out of reset fetches address 0
    pc_restart: assert property (@(posedge clk) $fell(reset) |-> pc == 32'd0)
        else $error("pc is 0x%h in the first cycle after reset", pc);

endmodule

bind mips_core mips_core_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .mem_read  (mem_read),
    .mem_write (mem_write)
);

//--- mips_core.sv
// Single-cycle MIPS32 subset; instr must follow pc combinationally from outside; no stalls or traps
`timescale 1ns/1ns

module mips_core
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    output word_t pc,
    output word_t alu_result,
    output logic  mem_read,
    output logic  mem_write,
    output logic  mem_to_reg
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm_ext;

    logic      reg_write;
    logic      alu_src;
    logic      reg_dst;
    logic      branch;
    alu_ctrl_t alu_ctrl;

    word_t     rs_data;
    word_t     rt_data;
    reg_addr_t write_reg;
    word_t     alu_b;
    logic      zero;
    word_t     mem_rdata;
    word_t     write_back;

    // Instruction fields
    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    mips_fetch u_fetch (
        .clk     (clk),
        .reset   (reset),
        .imm_ext (imm_ext),
        .branch  (branch),
        .zero    (zero),
        .pc      (pc)
    );

    mips_control u_control (
        .opcode     (opcode),
        .funct      (funct),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .reg_dst    (reg_dst),
        .branch     (branch),
        .mem_to_reg (mem_to_reg),
        .alu_ctrl   (alu_ctrl)
    );

    // rd for R-type, rt for addi and lw
    assign write_reg = reg_dst ? rd : rt;

    mips_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs_addr    (rs),
        .rt_addr    (rt),
        .rd_addr    (write_reg),
        .write_en   (reg_write),
        .write_data (write_back),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    // Immediate for addi, lw and sw
    assign alu_b = alu_src ? imm_ext : rt_data;

    mips_alu u_alu (
        .a        (rs_data),
        .b        (alu_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

    mips_data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk        (clk),
        .addr       (alu_result),
        .write_data (rt_data),
        .write_en   (mem_write),
        .read_en    (mem_read),
        .read_data  (mem_rdata)
    );

    // Write-back select
    assign write_back = mem_to_reg ? mem_rdata : alu_result;

endmodule

//--- mips_data_mem.sv
// DMEM_WORDS must be a power of two of at least 2; address bits 1:0 ignored, upper bits wrap; no reset
`timescale 1ns/1ns

module mips_data_mem
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic  clk,
    input  word_t addr,
    input  word_t write_data,
    input  logic  write_en,
    input  logic  read_en,
    output word_t read_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t             mem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    // Word index, upper address bits dropped
    assign idx = addr[IDX_W+1:2];

    // Read data is 0 unless a load is active
    assign read_data = read_en ? mem[idx] : '0;

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[idx] <= write_data;
        end
    end

endmodule

//--- mips_alu.sv
// Two's complement add and subtract wrap without overflow trap; slt compares signed; other codes give 0
`timescale 1ns/1ns

module mips_alu
    import mips_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_ctrl_t alu_ctrl,
    output word_t     result,
    output logic      zero
);

    word_t sum;
    word_t diff;
    logic  less;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (alu_ctrl)
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_SLT: begin
                result = {31'd0, less};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Used by beq
    assign zero = (result == '0);

endmodule

//--- mips_regfile.sv
// 32 registers cleared by reset; register 0 reads zero and ignores writes; write seen next cycle
`timescale 1ns/1ns

module mips_regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t rd_addr,
    input  logic      write_en,
    input  word_t     write_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];

    // Write port, register 0 stays at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= write_data;
        end
    end

    // Read ports, no bypass from the write port
    always_comb begin
        if (rs_addr == 5'd0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr == 5'd0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

//--- mips_control.sv
// Decodes add, sub, and, or, slt, addi, lw, sw and beq only; any other encoding writes nothing
`timescale 1ns/1ns

module mips_control
    import mips_pkg::*;
(
    input  opcode_t   opcode,
    input  funct_t    funct,
    output logic      reg_write,
    output logic      mem_read,
    output logic      mem_write,
    output logic      alu_src,
    output logic      reg_dst,
    output logic      branch,
    output logic      mem_to_reg,
    output alu_ctrl_t alu_ctrl
);

    alu_op_t alu_op;
    logic    dec_reg_write;
    logic    dec_mem_read;
    logic    dec_mem_write;
    logic    funct_ok;

    // Main decoder
    always_comb begin
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        alu_src       = 1'b0;
        reg_dst       = 1'b0;
        branch        = 1'b0;
        mem_to_reg    = 1'b0;
        alu_op        = ALU_OP_NONE;
        case (opcode)
            OP_RTYPE: begin
                dec_reg_write = 1'b1;
                reg_dst       = 1'b1;
                alu_op        = ALU_OP_RTYPE;
            end
            OP_LW: begin
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
                alu_src       = 1'b1;
                mem_to_reg    = 1'b1;
                alu_op        = ALU_OP_MEM;
            end
            OP_SW: begin
                dec_mem_write = 1'b1;
                alu_src       = 1'b1;
                alu_op        = ALU_OP_MEM;
            end
            OP_BEQ: begin
                branch = 1'b1;
                alu_op = ALU_OP_BRANCH;
            end
            OP_ADDI: begin
                dec_reg_write = 1'b1;
                alu_src       = 1'b1;
                alu_op        = ALU_OP_MEM;
            end
            default: ;
        endcase
    end

    // ALU control from class and funct
    always_comb begin
        funct_ok = 1'b1;
        alu_ctrl = ALU_NONE;
        case (alu_op)
            ALU_OP_MEM:    alu_ctrl = ALU_ADD;
            ALU_OP_BRANCH: alu_ctrl = ALU_SUB;
            ALU_OP_RTYPE: begin
                case (funct)
                    FN_ADD:  alu_ctrl = ALU_ADD;
                    FN_SUB:  alu_ctrl = ALU_SUB;
                    FN_AND:  alu_ctrl = ALU_AND;
                    FN_OR:   alu_ctrl = ALU_OR;
                    FN_SLT:  alu_ctrl = ALU_SLT;
                    default: funct_ok = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    // Unknown funct suppresses the register write
    assign reg_write = dec_reg_write & funct_ok;
    assign mem_read  = dec_mem_read;
    assign mem_write = dec_mem_write;

endmodule

//--- mips_fetch.sv
// Program counter resets to 0 and never stalls; branch offset is in words, relative to pc+4
`timescale 1ns/1ns

module mips_fetch
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t imm_ext,
    input  logic  branch,
    input  logic  zero,
    output word_t pc
);

    word_t pc_plus4;
    word_t branch_offset;
    word_t branch_target;
    word_t next_pc;
    logic  branch_taken;

    // Sequential address
    assign pc_plus4 = pc + 32'd4;

    // Word offset turned into a byte offset
    assign branch_offset = {imm_ext[29:0], 2'b00};
    assign branch_target = pc_plus4 + branch_offset;

    // beq taken only when the operands compared equal
    assign branch_taken = branch & zero;

    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- mips_pkg.sv
// Shared MIPS32 subset types and encodings; ALU control codes other than the five listed yield 0
package mips_pkg;

    // Data word, used for instructions, register values and addresses
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Primary opcode and R-type function fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // ALU operation selector
    typedef logic [3:0] alu_ctrl_t;

    // Operation class from the main decoder to ALU control
    typedef logic [1:0] alu_op_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_ADDI  = 6'b001000;

    // R-type function codes
    localparam funct_t FN_ADD = 6'b100000;
    localparam funct_t FN_SUB = 6'b100010;
    localparam funct_t FN_AND = 6'b100100;
    localparam funct_t FN_OR  = 6'b100101;
    localparam funct_t FN_SLT = 6'b101010;

    // ALU control codes, classic MIPS encoding
    localparam alu_ctrl_t ALU_AND = 4'b0000;
    localparam alu_ctrl_t ALU_OR  = 4'b0001;
    localparam alu_ctrl_t ALU_ADD = 4'b0010;
    localparam alu_ctrl_t ALU_SUB = 4'b0110;
    localparam alu_ctrl_t ALU_SLT = 4'b0111;

    // Code outside the set above, ALU drives 0 for it
    localparam alu_ctrl_t ALU_NONE = 4'b1111;

    // Operation classes
    // Loads, stores and addi add
    localparam alu_op_t ALU_OP_MEM    = 2'b00;
    // beq compares by subtracting
    localparam alu_op_t ALU_OP_BRANCH = 2'b01;
    // Operation taken from funct
    localparam alu_op_t ALU_OP_RTYPE  = 2'b10;
    // Unsupported opcode
    localparam alu_op_t ALU_OP_NONE   = 2'b11;

endpackage
